//--- source/entropy_pkg.sv
/*
 * Entropy expander package
 * Seed, store and state widths, timer widths, LFSR taps,
 * and the mode and error encodings shared by the expander blocks
 */
package entropy_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath geometry
  ////////////////////////////////////////////////////////////////////////////

  // One seed and one LFSR word
  localparam int unsigned SeedW = 64;

  // Entropy store holds five LFSR words
  localparam int unsigned StorageW = 320;
  localparam int unsigned StorageEntries = StorageW / SeedW;

  // Random state toward the hash core, five copies of the store
  localparam int unsigned StateW = 1600;

  // Wait timer and its prescaler
  localparam int unsigned TimerW = 16;
  localparam int unsigned PrescalerW = 10;

  // Error info field
  localparam int unsigned ErrInfoW = 8;

  // Fibonacci taps at positions 64, 63, 61 and 60 (1-based)
  localparam logic [SeedW-1:0] LfsrTaps = 64'hD800_0000_0000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Seed source, value 3 is invalid
  typedef enum logic [1:0] {
    ModeNone = 2'd0,
    ModeEdn  = 2'd1,
    ModeSw   = 2'd2
  } entropy_mode_e;

  // Reported error codes
  typedef enum logic [1:0] {
    ErrNone          = 2'd0,
    ErrWaitExpired   = 2'd1,
    ErrIncorrectMode = 2'd2
  } entropy_err_e;

endpackage

//--- source/entropy_wait_timer.sv
/*
 * Entropy wait timer
 * Prescaled down counter that watches the entropy source request
 * and flags expiry once the count reaches zero
 */
module entropy_wait_timer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               reload_i,
  input  logic                               enable_i,
  input  logic [entropy_pkg::PrescalerW-1:0] prescaler_i,
  input  logic [entropy_pkg::TimerW-1:0]     limit_i,
  output logic                               expired_o,
  output logic [entropy_pkg::TimerW-1:0]     value_o
);

  logic [entropy_pkg::PrescalerW-1:0] presc_q;
  logic                               tick;

  // One tick each time the prescaler wraps
  assign tick = enable_i && (presc_q == '0);

  // Prescaler
  // Reloads on request and after every tick
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_q <= '0;
    end else if (reload_i || tick) begin
      presc_q <= prescaler_i;
    end else if (enable_i) begin
      presc_q <= presc_q - 1'b1;
    end
  end

  // Wait counter
  // Stops at zero, only a reload moves it away
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      value_o <= '0;
    end else if (reload_i) begin
      value_o <= limit_i;
    end else if (tick && (value_o != '0)) begin
      value_o <= value_o - 1'b1;
    end
  end

  // Expiry flag, sticky until the next reload
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      expired_o <= 1'b0;
    end else if (reload_i) begin
      expired_o <= 1'b0;
    end else if (enable_i && (value_o == '0)) begin
      expired_o <= 1'b1;
    end
  end

  // Counter must have run out whenever expiry is reported
  a_expired_at_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    expired_o |-> (value_o == '0));

endmodule

//--- source/entropy_expander.sv
/*
 * Entropy expansion datapath
 * Picks the seed by mode, runs the LFSR one word per cycle into the
 * entropy store and replicates the store onto the random state
 */
module entropy_expander #(
  parameter int unsigned SeedWidth = entropy_pkg::SeedW
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  entropy_pkg::entropy_mode_e     mode_i,
  input  logic [SeedWidth-1:0]           edn_data_i,
  input  logic [SeedWidth-1:0]           sw_data_i,
  input  logic                           seed_load_i,
  input  logic                           fill_start_i,
  output logic                           filled_o,
  output logic [entropy_pkg::StateW-1:0] rand_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  // Narrower seeds give a deeper store of the same width
  localparam int unsigned Entries = entropy_pkg::StorageEntries *
                                    (entropy_pkg::SeedW / SeedWidth);
  localparam int unsigned IdxW = $clog2(Entries + 1);
  localparam int unsigned Copies = entropy_pkg::StateW / entropy_pkg::StorageW;

  // Taps keep their distance from the top bit
  localparam logic [SeedWidth-1:0] Taps =
    SeedWidth'(entropy_pkg::LfsrTaps >> (entropy_pkg::SeedW - SeedWidth));

  logic [SeedWidth-1:0]             seed;
  logic [SeedWidth-1:0]             lfsr_q;
  logic [SeedWidth-1:0]             lfsr_next;
  logic [entropy_pkg::StorageW-1:0] store_q;
  logic [IdxW-1:0]                  fill_idx_q;
  logic                             store_we;

  // Seed source by latched mode
  always_comb begin
    case (mode_i)
      entropy_pkg::ModeEdn: seed = edn_data_i;
      entropy_pkg::ModeSw:  seed = sw_data_i;
      default:              seed = '0;
    endcase
  end

  // Feedback bit enters at the low end
  assign lfsr_next = {lfsr_q[SeedWidth-2:0], ^(lfsr_q & Taps)};

  // Write while words remain, a new start takes the cycle
  assign filled_o = (fill_idx_q == IdxW'(Entries));
  assign store_we = !filled_o && !seed_load_i && !fill_start_i;

  // Fill index
  // Parks at the end after reset so nothing is written until started
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_idx_q <= IdxW'(Entries);
    end else if (seed_load_i || fill_start_i) begin
      fill_idx_q <= '0;
    end else if (store_we) begin
      fill_idx_q <= fill_idx_q + 1'b1;
    end
  end

  // LFSR, steps only with a store write
  always_ff @(posedge clk_i) begin
    if (seed_load_i) begin
      lfsr_q <= seed;
    end else if (store_we) begin
      lfsr_q <= lfsr_next;
    end
  end

  // Entropy store, word 0 in the low bits
  always_ff @(posedge clk_i) begin
    if (store_we) begin
      store_q[fill_idx_q*SeedWidth +: SeedWidth] <= lfsr_q;
    end
  end

  assign rand_data_o = {Copies{store_q}};

  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_idx_q <= IdxW'(Entries));

endmodule

//--- source/entropy_ctrl.sv
/*
 * Entropy expander controller
 * Sequences seeding, expansion, refresh and error reporting,
 * and owns the random-valid flag toward the hash core
 */
module entropy_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             entropy_ready_i,
  input  entropy_pkg::entropy_mode_e       mode_i,
  input  logic                             seed_update_i,
  input  logic                             entropy_ack_i,
  input  logic                             refresh_req_i,
  input  logic                             rand_consumed_i,
  input  logic                             err_processed_i,
  input  logic                             timer_expired_i,
  input  logic [entropy_pkg::TimerW-1:0]   timer_value_i,
  input  logic [entropy_pkg::TimerW-1:0]   limit_i,
  input  logic                             filled_i,
  output logic                             entropy_req_o,
  output logic                             rand_valid_o,
  output logic                             timer_reload_o,
  output logic                             timer_enable_o,
  output logic                             seed_load_o,
  output logic                             fill_start_o,
  output entropy_pkg::entropy_mode_e       mode_q_o,
  output logic                             err_valid_o,
  output entropy_pkg::entropy_err_e        err_code_o,
  output logic [entropy_pkg::ErrInfoW-1:0] err_info_o
);

  typedef enum logic [2:0] {
    StReset,
    StSeedWait,
    StRequest,
    StExpand,
    StReady,
    StWaitExpired,
    StIncorrectMode,
    StError
  } state_e;

  state_e state_q, state_d;
  logic   valid_set, valid_clr;
  logic   mode_latch;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StReset;
    end else begin
      state_q <= state_d;
    end
  end

  // Mode is fixed from leaving reset until the next reset state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q_o <= entropy_pkg::ModeNone;
    end else if (mode_latch) begin
      mode_q_o <= mode_i;
    end
  end

  // Valid level, set wins over clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rand_valid_o <= 1'b0;
    end else if (valid_set) begin
      rand_valid_o <= 1'b1;
    end else if (valid_clr) begin
      rand_valid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    valid_set      = 1'b0;
    valid_clr      = 1'b0;
    mode_latch     = 1'b0;
    entropy_req_o  = 1'b0;
    timer_reload_o = 1'b0;
    timer_enable_o = 1'b0;
    seed_load_o    = 1'b0;
    fill_start_o   = 1'b0;
    err_valid_o    = 1'b0;
    err_code_o     = entropy_pkg::ErrNone;
    err_info_o     = '0;

    case (state_q)
      StReset: begin
        if (entropy_ready_i) begin
          // Drop the dummy valid and pick the seed source
          valid_clr  = 1'b1;
          mode_latch = 1'b1;
          case (mode_i)
            entropy_pkg::ModeSw: state_d = StSeedWait;
            entropy_pkg::ModeEdn: begin
              timer_reload_o = 1'b1;
              state_d        = StRequest;
            end
            default: state_d = StIncorrectMode;
          endcase
        end else begin
          // Dummy valid lets the hash core leave reset on its own
          valid_set = 1'b1;
        end
      end

      StSeedWait: begin
        if (seed_update_i) begin
          seed_load_o = 1'b1;
          valid_clr   = 1'b1;
          state_d     = StExpand;
        end
      end

      StRequest: begin
        entropy_req_o  = 1'b1;
        timer_enable_o = 1'b1;
        // A zero limit never times out
        if (timer_expired_i && (limit_i != '0)) begin
          state_d = StWaitExpired;
        end else if (entropy_ack_i) begin
          seed_load_o = 1'b1;
          valid_clr   = 1'b1;
          state_d     = StExpand;
        end else if (rand_consumed_i) begin
          valid_clr = 1'b1;
        end
      end

      StExpand: begin
        if (filled_i) begin
          valid_set = 1'b1;
          state_d   = StReady;
        end
      end

      StReady: begin
        timer_enable_o = 1'b1;
        if (rand_consumed_i) begin
          // Refill continues the LFSR sequence
          fill_start_o = 1'b1;
          valid_clr    = 1'b1;
          state_d      = StExpand;
        end else if (refresh_req_i) begin
          timer_reload_o = 1'b1;
          state_d        = StRequest;
        end
      end

      StWaitExpired: begin
        err_valid_o = 1'b1;
        err_code_o  = entropy_pkg::ErrWaitExpired;
        err_info_o  = timer_value_i[entropy_pkg::ErrInfoW-1:0];
        state_d     = StError;
      end

      StIncorrectMode: begin
        err_valid_o = 1'b1;
        err_code_o  = entropy_pkg::ErrIncorrectMode;
        err_info_o  = entropy_pkg::ErrInfoW'(mode_q_o);
        state_d     = StError;
      end

      StError: begin
        // Keep the hash core going until software clears the error
        valid_set = 1'b1;
        if (err_processed_i) begin
          state_d = StReset;
        end
      end

      default: state_d = StReset;
    endcase
  end

  a_err_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_valid_o |=> !err_valid_o);

endmodule

//--- source/entropy_top.sv
/*
 * Entropy expander top level
 * Connects the wait timer, the expansion datapath and the controller
 */
module entropy_top #(
  parameter int unsigned SeedWidth = entropy_pkg::SeedW
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Entropy source handshake
  output logic                               entropy_req_o,
  input  logic                               entropy_ack_i,
  input  logic [SeedWidth-1:0]               entropy_data_i,
  // Random state toward the hash core
  output logic                               rand_valid_o,
  output logic [entropy_pkg::StateW-1:0]     rand_data_o,
  input  logic                               rand_consumed_i,
  // Software configuration
  input  entropy_pkg::entropy_mode_e         mode_i,
  input  logic                               entropy_ready_i,
  input  logic                               seed_update_i,
  input  logic [SeedWidth-1:0]               seed_data_i,
  input  logic                               refresh_req_i,
  input  logic [entropy_pkg::PrescalerW-1:0] wait_prescaler_i,
  input  logic [entropy_pkg::TimerW-1:0]     wait_limit_i,
  // Error report
  output logic                               err_valid_o,
  output entropy_pkg::entropy_err_e          err_code_o,
  output logic [entropy_pkg::ErrInfoW-1:0]   err_info_o,
  input  logic                               err_processed_i
);

  logic                           timer_reload;
  logic                           timer_enable;
  logic                           timer_expired;
  logic [entropy_pkg::TimerW-1:0] timer_value;
  logic                           seed_load;
  logic                           fill_start;
  logic                           filled;
  entropy_pkg::entropy_mode_e     mode_q;

  entropy_wait_timer i_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reload_i    (timer_reload),
    .enable_i    (timer_enable),
    .prescaler_i (wait_prescaler_i),
    .limit_i     (wait_limit_i),
    .expired_o   (timer_expired),
    .value_o     (timer_value)
  );

  entropy_expander #(
    .SeedWidth (SeedWidth)
  ) i_expander (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mode_i       (mode_q),
    .edn_data_i   (entropy_data_i),
    .sw_data_i    (seed_data_i),
    .seed_load_i  (seed_load),
    .fill_start_i (fill_start),
    .filled_o     (filled),
    .rand_data_o  (rand_data_o)
  );

  entropy_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .entropy_ready_i (entropy_ready_i),
    .mode_i          (mode_i),
    .seed_update_i   (seed_update_i),
    .entropy_ack_i   (entropy_ack_i),
    .refresh_req_i   (refresh_req_i),
    .rand_consumed_i (rand_consumed_i),
    .err_processed_i (err_processed_i),
    .timer_expired_i (timer_expired),
    .timer_value_i   (timer_value),
    .limit_i         (wait_limit_i),
    .filled_i        (filled),
    .entropy_req_o   (entropy_req_o),
    .rand_valid_o    (rand_valid_o),
    .timer_reload_o  (timer_reload),
    .timer_enable_o  (timer_enable),
    .seed_load_o     (seed_load),
    .fill_start_o    (fill_start),
    .mode_q_o        (mode_q),
    .err_valid_o     (err_valid_o),
    .err_code_o      (err_code_o),
    .err_info_o      (err_info_o)
  );

endmodule

//--- sim/tb_entropy_model.svh
/*
 * Entropy expander reference model
 * Tracks the 64-bit LFSR and the store fill, builds the expected
 * random state, and holds the value compare used by every check
 */
`ifndef TB_ENTROPY_MODEL_SVH
`define TB_ENTROPY_MODEL_SVH

// Widest value any check compares
localparam int unsigned CmpW = entropy_pkg::StateW;

logic [63:0]  model_lfsr;
logic [319:0] model_store;
int unsigned  model_writes;

// One Fibonacci step, taps at positions 64, 63, 61 and 60
function automatic logic [63:0] lfsr_advance(input logic [63:0] s);
  logic fb;
  fb = s[63] ^ s[62] ^ s[60] ^ s[59];
  return {s[62:0], fb};
endfunction

// New seed restarts the sequence
task automatic reseed_model(input logic [63:0] seed);
  model_lfsr   = seed;
  model_writes = 0;
endtask

// Five writes per fill, the running write count picks the word
task automatic fill_model();
  repeat (5) begin
    model_store[(model_writes % 5)*64 +: 64] = model_lfsr;
    model_lfsr                               = lfsr_advance(model_lfsr);
    model_writes++;
  end
endtask

// Store repeated five times toward the hash core
function automatic logic [CmpW-1:0] expected_state();
  return {5{model_store}};
endfunction

task automatic compare_value(input string name, input logic [CmpW-1:0] expected,
                             input logic [CmpW-1:0] actual);
  if (actual !== expected) begin
    $display("** Error at time %0t: %s expected %0h actual %0h",
             $time, name, expected, actual);
    end_with_failure();
  end
endtask

`endif

//--- sim/tb_entropy.sv
/*
 * Entropy expander testbench
 * Software and entropy-source seeding, consumes, refresh, timeout
 * and invalid mode, checked against the LFSR model
 */
module tb_entropy;

  localparam int SigReq   = 0;
  localparam int SigValid = 1;
  localparam int SigErr   = 2;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               entropy_req_o;
  logic                               entropy_ack_i;
  logic [entropy_pkg::SeedW-1:0]      entropy_data_i;
  logic                               rand_valid_o;
  logic [entropy_pkg::StateW-1:0]     rand_data_o;
  logic                               rand_consumed_i;
  entropy_pkg::entropy_mode_e         mode_i;
  logic                               entropy_ready_i;
  logic                               seed_update_i;
  logic [entropy_pkg::SeedW-1:0]      seed_data_i;
  logic                               refresh_req_i;
  logic [entropy_pkg::PrescalerW-1:0] wait_prescaler_i;
  logic [entropy_pkg::TimerW-1:0]     wait_limit_i;
  logic                               err_valid_o;
  entropy_pkg::entropy_err_e          err_code_o;
  logic [entropy_pkg::ErrInfoW-1:0]   err_info_o;
  logic                               err_processed_i;

  `include "tb_entropy_model.svh"

  entropy_top #(
    .SeedWidth (entropy_pkg::SeedW)
  ) i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .entropy_req_o    (entropy_req_o),
    .entropy_ack_i    (entropy_ack_i),
    .entropy_data_i   (entropy_data_i),
    .rand_valid_o     (rand_valid_o),
    .rand_data_o      (rand_data_o),
    .rand_consumed_i  (rand_consumed_i),
    .mode_i           (mode_i),
    .entropy_ready_i  (entropy_ready_i),
    .seed_update_i    (seed_update_i),
    .seed_data_i      (seed_data_i),
    .refresh_req_i    (refresh_req_i),
    .wait_prescaler_i (wait_prescaler_i),
    .wait_limit_i     (wait_limit_i),
    .err_valid_o      (err_valid_o),
    .err_code_o       (err_code_o),
    .err_info_o       (err_info_o),
    .err_processed_i  (err_processed_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // Ten cycles of reset with every control input idle
  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni          <= 1'b0;
    entropy_ready_i <= 1'b0;
    seed_update_i   <= 1'b0;
    refresh_req_i   <= 1'b0;
    rand_consumed_i <= 1'b0;
    entropy_ack_i   <= 1'b0;
    err_processed_i <= 1'b0;
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("rand_valid_o", CmpW'(1'b0), CmpW'(rand_valid_o));
    @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  function automatic logic probe(input int which);
    case (which)
      SigReq:   return entropy_req_o;
      SigValid: return rand_valid_o;
      default:  return err_valid_o;
    endcase
  endfunction

  // Sampled on the falling edge, gives up after limit cycles
  task automatic wait_until_high(input int which, input string name,
                                 input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!probe(which)) begin
      if (n == limit) begin
        $display("Timeout: %s did not rise within %0d cycles", name, limit);
        end_with_failure();
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  // Valid low until the sixth edge after the start edge, high from that edge on
  task automatic check_expansion();
    for (int k = 1; k <= 7; k++) begin
      @(negedge clk_i);
      compare_value("rand_valid_o", CmpW'(k == 7), CmpW'(rand_valid_o));
      compare_value("entropy_req_o", CmpW'(1'b0), CmpW'(entropy_req_o));
      compare_value("err_valid_o", CmpW'(1'b0), CmpW'(err_valid_o));
    end
    fill_model();
    compare_value("rand_data_o", expected_state(), rand_data_o);
  endtask

  task automatic software_seed(input logic [63:0] seed);
    @(posedge clk_i);
    seed_data_i   <= seed;
    seed_update_i <= 1'b1;
    @(posedge clk_i);
    seed_update_i <= 1'b0;
    reseed_model(seed);
    check_expansion();
  endtask

  task automatic consume_once();
    @(posedge clk_i);
    rand_consumed_i <= 1'b1;
    @(posedge clk_i);
    rand_consumed_i <= 1'b0;
    check_expansion();
  endtask

  // Answer the pending request after a random delay with random data
  task automatic source_acknowledge();
    int unsigned delay;
    logic [63:0] data;
    wait_until_high(SigReq, "entropy_req_o", 20);
    delay = $urandom_range(0, 7);
    data  = {$urandom, $urandom};
    repeat (delay) @(posedge clk_i);
    @(posedge clk_i);
    entropy_ack_i  <= 1'b1;
    entropy_data_i <= data;
    @(posedge clk_i);
    entropy_ack_i <= 1'b0;
    reseed_model(data);
    check_expansion();
  endtask

  // Raise entropy_ready_i for one sampled cycle with the given mode
  task automatic start_mode(input entropy_pkg::entropy_mode_e mode);
    @(posedge clk_i);
    mode_i          <= mode;
    entropy_ready_i <= 1'b1;
    @(posedge clk_i);
    entropy_ready_i <= 1'b0;
  endtask

  task automatic clear_error();
    @(posedge clk_i);
    err_processed_i <= 1'b1;
    @(posedge clk_i);
    err_processed_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Behavior sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned gap;
    void'($urandom(32'h777e6cb3));
    rst_ni           = 1'b0;
    entropy_ack_i    = 1'b0;
    entropy_data_i   = '0;
    rand_consumed_i  = 1'b0;
    mode_i           = entropy_pkg::ModeNone;
    entropy_ready_i  = 1'b0;
    seed_update_i    = 1'b0;
    seed_data_i      = '0;
    refresh_req_i    = 1'b0;
    wait_prescaler_i = '0;
    wait_limit_i     = '0;
    err_processed_i  = 1'b0;

    // Dummy valid after reset
    apply_reset();
    wait_until_high(SigValid, "rand_valid_o", 3);
    compare_value("entropy_req_o", CmpW'(1'b0), CmpW'(entropy_req_o));
    compare_value("err_valid_o", CmpW'(1'b0), CmpW'(err_valid_o));

    // Software seed, the ready edge drops the dummy valid
    start_mode(entropy_pkg::ModeSw);
    @(negedge clk_i);
    compare_value("rand_valid_o", CmpW'(1'b0), CmpW'(rand_valid_o));
    software_seed({$urandom, $urandom});

    // Refills continue the LFSR sequence
    repeat (4) begin
      gap = $urandom_range(0, 6);
      repeat (gap) @(posedge clk_i);
      consume_once();
    end

    // Entropy source seed without timeout, then a refresh
    apply_reset();
    wait_until_high(SigValid, "rand_valid_o", 3);
    @(posedge clk_i);
    wait_limit_i <= '0;
    start_mode(entropy_pkg::ModeEdn);
    source_acknowledge();
    consume_once();
    @(posedge clk_i);
    refresh_req_i <= 1'b1;
    @(posedge clk_i);
    refresh_req_i <= 1'b0;
    source_acknowledge();

    // Source never answers
    apply_reset();
    wait_until_high(SigValid, "rand_valid_o", 3);
    @(posedge clk_i);
    wait_prescaler_i <= 10'd2;
    wait_limit_i     <= 16'd3;
    start_mode(entropy_pkg::ModeEdn);
    wait_until_high(SigReq, "entropy_req_o", 5);
    wait_until_high(SigErr, "err_valid_o", 200);
    compare_value("err_code_o", CmpW'(entropy_pkg::ErrWaitExpired), CmpW'(err_code_o));
    compare_value("err_info_o", CmpW'(8'd0), CmpW'(err_info_o));
    clear_error();
    wait_until_high(SigValid, "rand_valid_o", 3);
    repeat (3) begin
      @(negedge clk_i);
      compare_value("entropy_req_o", CmpW'(1'b0), CmpW'(entropy_req_o));
      compare_value("rand_valid_o", CmpW'(1'b1), CmpW'(rand_valid_o));
    end

    // Only the reset state takes a new ready and drops the dummy valid
    start_mode(entropy_pkg::ModeSw);
    @(negedge clk_i);
    compare_value("rand_valid_o", CmpW'(1'b0), CmpW'(rand_valid_o));

    // Unused mode encoding
    apply_reset();
    wait_until_high(SigValid, "rand_valid_o", 3);
    start_mode(entropy_pkg::entropy_mode_e'(2'd3));
    wait_until_high(SigErr, "err_valid_o", 5);
    compare_value("err_code_o", CmpW'(entropy_pkg::ErrIncorrectMode), CmpW'(err_code_o));
    compare_value("err_info_o", CmpW'(8'd3), CmpW'(err_info_o));
    clear_error();

    @(posedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- tb.f
+incdir+sim
source/entropy_pkg.sv
source/entropy_wait_timer.sv
source/entropy_expander.sv
source/entropy_ctrl.sv
source/entropy_top.sv
sim/tb_entropy.sv

//--- run.sh
#!/usr/bin/env bash
# Build the entropy expander testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_entropy -f tb.f -o tb_entropy \
  && ./obj_dir/tb_entropy 2>&1 | tee sim.log
grep -qx "Done: no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
